//--- Bender.yml
package:
  name: l1_cache

sources:
  - cache_cfg_pkg.sv
  - cache_ctrl_pkg.sv
  - cache_line_ram.sv
  - cache_datapath.sv
  - l1_cache_controller.sv
  - l1_cache_top.sv
  - target: simulation
    files:
      - l1_cache_chk.sv
      - tb_l1_cache.sv

//--- cache_cfg_pkg.sv
package cache_cfg_pkg;

	// Cache geometry.
	// One word per line, direct mapped.
	localparam int addr_w = 16;
	localparam int data_w = 32;
	localparam int index_w = 4;
	localparam int tag_w = addr_w - index_w;
	localparam int num_lines = 1 << index_w;

	// Word address, split as {tag, index}.
	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] data_t;
	typedef logic [index_w-1:0] index_t;
	typedef logic [tag_w-1:0] tag_t;

	// Entry of the tag RAM.
	// Valid bits live outside the RAM so that reset can clear them.
	typedef struct packed {
		tag_t tag;
		logic dirty;
	} tag_entry_t;

endpackage

//--- cache_ctrl_pkg.sv
package cache_ctrl_pkg;

	// Controller states.
	typedef enum logic [2:0] {
		st_idle,
		st_compare,
		st_read_miss,
		st_read_data,
		st_write_hit,
		st_write_miss,
		st_write_data,
		st_write_back
	} state_t;

	// Source of the word written into the data RAM.
	typedef enum logic {
		sel_cpu,
		sel_dram
	} data_sel_t;

endpackage

//--- cache_datapath.sv
`timescale 1ns/1ps

module cache_datapath (
	input  logic                       clk,
	input  logic                       rst,

	// Strobes from the controller.
	input  logic                       req_capture,
	input  logic                       cache_we,
	input  logic                       sram_we,
	input  logic                       cache_dirty_o,
	input  cache_ctrl_pkg::data_sel_t  sram_data_sel,
	input  logic                       dram_we,

	// Request and DRAM data.
	input  cache_cfg_pkg::addr_t       cpu_addr,
	input  cache_cfg_pkg::data_t       cpu_wdata,
	input  cache_cfg_pkg::data_t       dram_rdata,

	// Status back to the controller.
	output logic                       cache_hit,
	output logic                       cache_valid,
	output logic                       cache_dirty_i,
	output logic                       req_we,

	output cache_cfg_pkg::data_t       cpu_rdata,
	output cache_cfg_pkg::addr_t       dram_addr,
	output cache_cfg_pkg::data_t       dram_wdata
);

	cache_cfg_pkg::addr_t req_addr;
	cache_cfg_pkg::data_t req_wdata;
	cache_cfg_pkg::data_t fill_data;
	cache_cfg_pkg::index_t req_index;
	cache_cfg_pkg::tag_t req_tag;
	logic [cache_cfg_pkg::num_lines-1:0] valid_q;

	cache_cfg_pkg::tag_entry_t tag_wr;
	cache_cfg_pkg::tag_entry_t tag_rd;
	cache_cfg_pkg::data_t data_wr;
	cache_cfg_pkg::data_t data_rd;

	// Request capture.
	always_ff @(posedge clk)
	begin
		if (req_capture)
		begin
			req_addr <= cpu_addr;
			req_wdata <= cpu_wdata;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			req_we <= 1'b0;
		else if (req_capture)
			req_we <= cache_we;
	end

	// DRAM word from the ack cycle, written one cycle later.
	always_ff @(posedge clk)
	begin
		fill_data <= dram_rdata;
	end

	assign req_index = req_addr[cache_cfg_pkg::index_w-1:0];
	assign req_tag = req_addr[cache_cfg_pkg::addr_w-1:cache_cfg_pkg::index_w];

	// Valid bits, set by any write of the line.
	always_ff @(posedge clk)
	begin
		if (!rst)
			valid_q <= '0;
		else if (sram_we)
			valid_q[req_index] <= 1'b1;
	end

	assign tag_wr.tag = req_tag;
	assign tag_wr.dirty = cache_dirty_o;
	assign data_wr = (sram_data_sel == cache_ctrl_pkg::sel_dram) ? fill_data : req_wdata;

	cache_line_ram #(
		.entry_t (cache_cfg_pkg::tag_entry_t)
	) u_tag_ram (
		.clk    (clk),
		.we     (sram_we),
		.index  (req_index),
		.wentry (tag_wr),
		.rentry (tag_rd)
	);

	cache_line_ram #(
		.entry_t (cache_cfg_pkg::data_t)
	) u_data_ram (
		.clk    (clk),
		.we     (sram_we),
		.index  (req_index),
		.wentry (data_wr),
		.rentry (data_rd)
	);

	// Line status for the captured index.
	assign cache_hit = (tag_rd.tag == req_tag);
	assign cache_valid = valid_q[req_index];
	assign cache_dirty_i = tag_rd.dirty;

	assign cpu_rdata = data_rd;

	// Write back goes to the victim, a fill to the request.
	assign dram_addr = dram_we ? {tag_rd.tag, req_index} : req_addr;
	assign dram_wdata = data_rd;

endmodule

//--- cache_line_ram.sv
`timescale 1ns/1ps

module cache_line_ram #(
	parameter type entry_t = logic [cache_cfg_pkg::data_w-1:0]
) (
	input  logic                  clk,
	input  logic                  we,
	input  cache_cfg_pkg::index_t index,
	input  entry_t                wentry,
	output entry_t                rentry
);

	// One entry per cache line.
	entry_t mem [cache_cfg_pkg::num_lines];

	// Write on the clock edge.
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[index] <= wentry;
		end
	end

	// Read is asynchronous, so the tag compare settles in the same cycle.
	assign rentry = mem[index];

endmodule

//--- l1_cache.f
cache_cfg_pkg.sv
cache_ctrl_pkg.sv
cache_line_ram.sv
cache_datapath.sv
l1_cache_controller.sv
l1_cache_top.sv
l1_cache_chk.sv
tb_l1_cache.sv

//--- l1_cache_chk.sv
`timescale 1ns/1ps

module l1_cache_chk (
	input logic                   clk,
	input logic                   rst,
	input cache_ctrl_pkg::state_t state,
	input logic                   cache_ack,
	input logic                   sram_we,
	input logic                   dram_cs,
	input logic                   dram_we,
	input logic                   dram_ack
);

	// Number of failed assertions.
	int fail_count = 0;

	// A write back always selects the DRAM.
	we_with_cs: assert property (@(posedge clk) disable iff (!rst) dram_we |-> dram_cs)
	else
	begin
		fail_count++;
		$error("dram_we high without dram_cs");
	end

	// Completion is a single pulse, then the FSM is idle.
	ack_pulse: assert property (@(posedge clk) disable iff (!rst)
		cache_ack |=> !cache_ack && state == cache_ctrl_pkg::st_idle)
	else
	begin
		fail_count++;
		$error("cache_ack longer than one cycle");
	end

	no_overlap: assert property (@(posedge clk) disable iff (!rst) !(sram_we && dram_cs))
	else
	begin
		fail_count++;
		$error("sram_we and dram_cs high together");
	end

	// The DRAM request is held until it is acknowledged.
	cs_held: assert property (@(posedge clk) disable iff (!rst) dram_cs && !dram_ack |=> dram_cs)
	else
	begin
		fail_count++;
		$error("dram_cs dropped before dram_ack");
	end

endmodule

//--- l1_cache_controller.sv
`timescale 1ns/1ps

module l1_cache_controller (
	input  logic                       clk,
	input  logic                       rst,

	// CPU side.
	input  logic                       cache_cs,
	output logic                       cache_ack,

	// Datapath side.
	input  logic                       cache_hit,
	input  logic                       cache_valid,
	input  logic                       cache_dirty_i,
	input  logic                       req_we,
	output logic                       req_capture,
	output logic                       sram_we,
	output logic                       cache_dirty_o,
	output cache_ctrl_pkg::data_sel_t  sram_data_sel,

	// DRAM side.
	output logic                       dram_cs,
	output logic                       dram_we,
	input  logic                       dram_ack
);

	cache_ctrl_pkg::state_t state;
	cache_ctrl_pkg::state_t next_state;
	logic line_hit;

	assign line_hit = cache_hit && cache_valid;

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= cache_ctrl_pkg::st_idle;
		else
			state <= next_state;
	end

	// Next state.
	always_comb
	begin
		next_state = state;
		case (state)
			cache_ctrl_pkg::st_idle:
			begin
				if (cache_cs)
					next_state = cache_ctrl_pkg::st_compare;
			end

			cache_ctrl_pkg::st_compare:
			begin
				if (line_hit)
				begin
					if (req_we)
						next_state = cache_ctrl_pkg::st_write_hit;
					else
						next_state = cache_ctrl_pkg::st_idle;
				end
				else if (cache_valid && cache_dirty_i)
					next_state = cache_ctrl_pkg::st_write_back;
				else if (req_we)
					next_state = cache_ctrl_pkg::st_write_miss;
				else
					next_state = cache_ctrl_pkg::st_read_miss;
			end

			// Wait for the fill word.
			cache_ctrl_pkg::st_read_miss:
			begin
				if (dram_ack)
					next_state = cache_ctrl_pkg::st_read_data;
			end

			// Back to compare, which then hits and acks.
			cache_ctrl_pkg::st_read_data:
				next_state = cache_ctrl_pkg::st_compare;

			cache_ctrl_pkg::st_write_hit:
				next_state = cache_ctrl_pkg::st_idle;

			cache_ctrl_pkg::st_write_miss:
			begin
				if (dram_ack)
					next_state = cache_ctrl_pkg::st_write_data;
			end

			cache_ctrl_pkg::st_write_data:
				next_state = cache_ctrl_pkg::st_write_hit;

			// Victim is out, so fetch the new line directly.
			cache_ctrl_pkg::st_write_back:
			begin
				if (dram_ack)
				begin
					if (req_we)
						next_state = cache_ctrl_pkg::st_write_miss;
					else
						next_state = cache_ctrl_pkg::st_read_miss;
				end
			end

			default:
				next_state = cache_ctrl_pkg::st_idle;
		endcase
	end

	assign req_capture = (state == cache_ctrl_pkg::st_idle) && cache_cs;

	// Outputs decoded per state.
	always_comb
	begin
		cache_ack = 1'b0;
		sram_we = 1'b0;
		cache_dirty_o = 1'b0;
		sram_data_sel = cache_ctrl_pkg::sel_cpu;
		dram_cs = 1'b0;
		dram_we = 1'b0;
		case (state)
			cache_ctrl_pkg::st_compare:
				cache_ack = line_hit && !req_we;

			cache_ctrl_pkg::st_read_miss,
			cache_ctrl_pkg::st_write_miss:
				dram_cs = 1'b1;

			// Clean fill from DRAM.
			cache_ctrl_pkg::st_read_data,
			cache_ctrl_pkg::st_write_data:
			begin
				sram_we = 1'b1;
				sram_data_sel = cache_ctrl_pkg::sel_dram;
			end

			// CPU word in, line now dirty.
			cache_ctrl_pkg::st_write_hit:
			begin
				sram_we = 1'b1;
				cache_dirty_o = 1'b1;
				cache_ack = 1'b1;
			end

			cache_ctrl_pkg::st_write_back:
			begin
				dram_cs = 1'b1;
				dram_we = 1'b1;
			end

			default:
			begin
				cache_ack = 1'b0;
			end
		endcase
	end

endmodule

//--- l1_cache_top.sv
`timescale 1ns/1ps

module l1_cache_top (
	input  logic                  clk,
	input  logic                  rst,

	// CPU port.
	input  logic                  cache_cs,
	input  logic                  cache_we,
	input  cache_cfg_pkg::addr_t  cpu_addr,
	input  cache_cfg_pkg::data_t  cpu_wdata,
	output logic                  cache_ack,
	output cache_cfg_pkg::data_t  cpu_rdata,

	// DRAM port.
	output logic                  dram_cs,
	output logic                  dram_we,
	output cache_cfg_pkg::addr_t  dram_addr,
	output cache_cfg_pkg::data_t  dram_wdata,
	input  cache_cfg_pkg::data_t  dram_rdata,
	input  logic                  dram_ack
);

	logic req_capture;
	logic sram_we;
	logic cache_dirty_o;
	cache_ctrl_pkg::data_sel_t sram_data_sel;
	logic cache_hit;
	logic cache_valid;
	logic cache_dirty_i;
	logic req_we;

	l1_cache_controller u_ctrl (
		.clk           (clk),
		.rst           (rst),
		.cache_cs      (cache_cs),
		.cache_ack     (cache_ack),
		.cache_hit     (cache_hit),
		.cache_valid   (cache_valid),
		.cache_dirty_i (cache_dirty_i),
		.req_we        (req_we),
		.req_capture   (req_capture),
		.sram_we       (sram_we),
		.cache_dirty_o (cache_dirty_o),
		.sram_data_sel (sram_data_sel),
		.dram_cs       (dram_cs),
		.dram_we       (dram_we),
		.dram_ack      (dram_ack)
	);

	cache_datapath u_dp (
		.clk           (clk),
		.rst           (rst),
		.req_capture   (req_capture),
		.cache_we      (cache_we),
		.sram_we       (sram_we),
		.cache_dirty_o (cache_dirty_o),
		.sram_data_sel (sram_data_sel),
		.dram_we       (dram_we),
		.cpu_addr      (cpu_addr),
		.cpu_wdata     (cpu_wdata),
		.dram_rdata    (dram_rdata),
		.cache_hit     (cache_hit),
		.cache_valid   (cache_valid),
		.cache_dirty_i (cache_dirty_i),
		.req_we        (req_we),
		.cpu_rdata     (cpu_rdata),
		.dram_addr     (dram_addr),
		.dram_wdata    (dram_wdata)
	);

endmodule

//--- tb_l1_cache.sv
`timescale 1ns/1ps

module tb_l1_cache;

	logic clk;
	logic rst;
	logic cache_cs;
	logic cache_we;
	cache_cfg_pkg::addr_t cpu_addr;
	cache_cfg_pkg::data_t cpu_wdata;
	logic cache_ack;
	cache_cfg_pkg::data_t cpu_rdata;
	logic dram_cs;
	logic dram_we;
	cache_cfg_pkg::addr_t dram_addr;
	cache_cfg_pkg::data_t dram_wdata;
	cache_cfg_pkg::data_t dram_rdata;
	logic dram_ack;

	// DRAM contents and the true value of every word.
	cache_cfg_pkg::data_t dram_mem [1 << cache_cfg_pkg::addr_w];
	cache_cfg_pkg::data_t shadow [1 << cache_cfg_pkg::addr_w];

	// Expected line state under the direct-mapped rule.
	cache_cfg_pkg::tag_t sh_tag [cache_cfg_pkg::num_lines];
	logic [cache_cfg_pkg::num_lines-1:0] sh_valid;
	logic [cache_cfg_pkg::num_lines-1:0] sh_dirty;

	// DRAM accesses seen during one CPU request.
	cache_cfg_pkg::addr_t log_addr [$];
	logic log_we [$];
	cache_cfg_pkg::data_t log_wdata [$];

	// Cycles with dram_cs high during one CPU request.
	int cs_cycles;

	logic [31:0] lfsr;
	int dram_wait;

	l1_cache_top u_l1_cache_top (
		.clk        (clk),
		.rst        (rst),
		.cache_cs   (cache_cs),
		.cache_we   (cache_we),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cache_ack  (cache_ack),
		.cpu_rdata  (cpu_rdata),
		.dram_cs    (dram_cs),
		.dram_we    (dram_we),
		.dram_addr  (dram_addr),
		.dram_wdata (dram_wdata),
		.dram_rdata (dram_rdata),
		.dram_ack   (dram_ack)
	);

	bind l1_cache_controller l1_cache_chk u_chk (
		.clk       (clk),
		.rst       (rst),
		.state     (state),
		.cache_ack (cache_ack),
		.sram_we   (sram_we),
		.dram_cs   (dram_cs),
		.dram_we   (dram_we),
		.dram_ack  (dram_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_data(input string name, input cache_cfg_pkg::data_t got,
		input cache_cfg_pkg::data_t exp);
		if (got !== exp)
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input cache_cfg_pkg::addr_t got,
		input cache_cfg_pkg::addr_t exp);
		if (got !== exp)
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	// Galois LFSR for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// DRAM model with a random latency of 1 to 8 cycles.
	always @(posedge clk)
	begin
		logic [31:0] lat;
		#1;
		if (rst && dram_cs)
			cs_cycles++;
		if (!rst || dram_ack)
		begin
			dram_ack = 1'b0;
			dram_rdata = 32'hdead_beef;
			dram_wait = 0;
		end
		else if (dram_cs)
		begin
			if (dram_wait == 0)
			begin
				take_bits(3, lat);
				dram_wait = lat + 1;
			end
			dram_wait--;
			if (dram_wait == 0)
			begin
				log_addr.push_back(dram_addr);
				log_we.push_back(dram_we);
				log_wdata.push_back(dram_wdata);
				if (dram_we)
					dram_mem[dram_addr] = dram_wdata;
				dram_rdata = dram_mem[dram_addr];
				dram_ack = 1'b1;
			end
		end
	end

	task automatic apply_reset();
		int i;
		cache_cfg_pkg::addr_t a;
		@(posedge clk);
		#1;
		rst = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b1;
		// Dirty lines are lost, so DRAM holds the true value again.
		for (i = 0; i < cache_cfg_pkg::num_lines; i++)
		begin
			a = {sh_tag[i], cache_cfg_pkg::index_t'(i)};
			if (sh_valid[i] && sh_dirty[i])
				shadow[a] = dram_mem[a];
		end
		sh_valid = '0;
		sh_dirty = '0;
	endtask

	// One CPU request held until cache_ack.
	task automatic run_access(input logic we, input cache_cfg_pkg::addr_t addr,
		input cache_cfg_pkg::data_t wdata, output cache_cfg_pkg::data_t rdata, output int lat);
		int cycles;
		@(posedge clk);
		#1;
		cache_cs = 1'b1;
		cache_we = we;
		cpu_addr = addr;
		cpu_wdata = wdata;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!cache_ack && cycles < 200);
		if (!cache_ack)
			abort_run("timeout, no cache_ack within 200 cycles");
		rdata = cpu_rdata;
		lat = cycles - 1;
		@(posedge clk);
		#1;
		cache_cs = 1'b0;
		cache_we = 1'b0;
	endtask

	task automatic access_and_check(input logic we, input cache_cfg_pkg::addr_t addr,
		input cache_cfg_pkg::data_t wdata);
		cache_cfg_pkg::index_t idx;
		cache_cfg_pkg::addr_t victim;
		cache_cfg_pkg::data_t got;
		logic hit;
		logic evict;
		int lat;
		int n;
		idx = addr[cache_cfg_pkg::index_w-1:0];
		hit = sh_valid[idx]
			&& (sh_tag[idx] == addr[cache_cfg_pkg::addr_w-1:cache_cfg_pkg::index_w]);
		evict = !hit && sh_valid[idx] && sh_dirty[idx];
		victim = {sh_tag[idx], idx};
		log_addr.delete();
		log_we.delete();
		log_wdata.delete();
		cs_cycles = 0;
		run_access(we, addr, wdata, got, lat);
		if (hit)
		begin
			check_count("dram accesses", log_addr.size(), 0);
			check_count("dram_cs cycles", cs_cycles, 0);
			check_count("ack latency", lat, we ? 2 : 1);
		end
		else
		begin
			n = evict ? 2 : 1;
			check_count("dram accesses", log_addr.size(), n);
			// Victim goes out before the fill.
			if (evict)
			begin
				check_bit("dram_we", log_we[0], 1'b1);
				check_addr("dram_addr", log_addr[0], victim);
				check_data("dram_wdata", log_wdata[0], shadow[victim]);
			end
			check_bit("dram_we", log_we[n-1], 1'b0);
			check_addr("dram_addr", log_addr[n-1], addr);
		end
		if (we)
			shadow[addr] = wdata;
		else
			check_data("cpu_rdata", got, shadow[addr]);
		sh_dirty[idx] = hit ? (sh_dirty[idx] | we) : we;
		sh_valid[idx] = 1'b1;
		sh_tag[idx] = addr[cache_cfg_pkg::addr_w-1:cache_cfg_pkg::index_w];
	endtask

	// Line 3 holds 0x0123 first, then 0x0453.
	task automatic read_miss_fill();
		access_and_check(1'b0, 16'h0123, '0);
	endtask

	task automatic read_hit_repeat();
		access_and_check(1'b0, 16'h0123, '0);
	endtask

	task automatic write_hit_then_read();
		access_and_check(1'b1, 16'h0123, 32'hc0de_0001);
		access_and_check(1'b0, 16'h0123, '0);
	endtask

	task automatic dirty_eviction();
		access_and_check(1'b0, 16'h0453, '0);
	endtask

	task automatic reset_invalidates();
		apply_reset();
		access_and_check(1'b0, 16'h0453, '0);
	endtask

	// 64 words over 16 lines, so evictions are frequent.
	task automatic random_mix();
		int k;
		logic [31:0] we;
		logic [31:0] addr;
		logic [31:0] wdata;
		for (k = 0; k < 200; k++)
		begin
			take_bits(1, we);
			take_bits(6, addr);
			take_bits(32, wdata);
			access_and_check(we[0], cache_cfg_pkg::addr_t'(addr), wdata);
		end
	endtask

	initial
	begin
		int i;
		rst = 1'b0;
		cache_cs = 1'b0;
		cache_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		dram_rdata = '0;
		dram_ack = 1'b0;
		dram_wait = 0;
		cs_cycles = 0;
		lfsr = 32'd95909;
		sh_valid = '0;
		sh_dirty = '0;
		for (i = 0; i < (1 << cache_cfg_pkg::addr_w); i++)
		begin
			dram_mem[i] = {i[15:0], ~i[15:0]};
			shadow[i] = dram_mem[i];
		end
		apply_reset();
		read_miss_fill();
		read_hit_repeat();
		write_hit_then_read();
		dirty_eviction();
		reset_invalidates();
		random_mix();
		if (u_l1_cache_top.u_ctrl.u_chk.fail_count != 0)
			abort_run("the controller checker reported assertion failures");
		else
		begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule
